// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = rooth_mem_tb
FILELIST  = rooth_mem.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/rooth_pkg.sv
package rooth_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int CSR_AW = 12;

    // routing class from execute
    typedef enum logic [1:0] {
        RES_REG  = 2'd0,
        RES_MEM  = 2'd1,    // store
        RES_CSR  = 2'd2,
        RES_NONE = 2'd3
    } res_ctrl_e;

    // decoded access kind
    typedef enum logic [2:0] {
        ACC_ALU   = 3'd0,
        ACC_LOAD  = 3'd1,
        ACC_STORE = 3'd2,
        ACC_CSR   = 3'd3,
        ACC_NONE  = 3'd4
    } access_e;

    // ------------------------------------------------------------------
    // funct3 codes
    // ------------------------------------------------------------------
    localparam logic [2:0] F3_LB     = 3'b000;
    localparam logic [2:0] F3_LH     = 3'b001;
    localparam logic [2:0] F3_LW     = 3'b010;
    localparam logic [2:0] F3_LBU    = 3'b100;
    localparam logic [2:0] F3_LHU    = 3'b101;

    localparam logic [2:0] F3_SB     = 3'b000;
    localparam logic [2:0] F3_SH     = 3'b001;
    localparam logic [2:0] F3_SW     = 3'b010;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;

    // ------------------------------------------------------------------
    // stage records
    // ------------------------------------------------------------------
    typedef struct packed {
        res_ctrl_e          res_ctrl;
        logic               is_load;
        logic [2:0]         funct3;
        logic [REG_AW-1:0]  rd;
        logic [CSR_AW-1:0]  csr_idx;
        logic [XLEN-1:0]    alu_res;    // also the load/store address
        logic [XLEN-1:0]    rs1;
        logic [XLEN-1:0]    rs2;
        logic [XLEN-1:0]    imm;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        access_e            kind;
        logic               in_ram;     // region 0
        logic [1:0]         lane;
        logic [2:0]         funct3;
        logic [REG_AW-1:0]  rd;
        logic [CSR_AW-1:0]  csr_idx;
        logic [XLEN-1:0]    alu_res;
        logic [XLEN-1:0]    rs1;
        logic [XLEN-1:0]    rs2;
        logic [XLEN-1:0]    imm;
    } mem_op_t;

    typedef struct packed {
        logic               we;
        logic [REG_AW-1:0]  rd;
        logic [XLEN-1:0]    data;
        logic               fault;
    } wb_t;

endpackage

// File: mem_stage/data_ram.sv
`timescale 1ns/1ns

module data_ram
    import rooth_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,

    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(RAM_WORDS)-1:0] addr_i,
    input  logic [XLEN-1:0]              wdata_i,
    output logic [XLEN-1:0]              rdata_o
);

    logic [XLEN-1:0] mem [RAM_WORDS];

    // ------------------------------------------------------------------
    // single port, one cycle read latency
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;     // rdata_o keeps last read
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// File: mem_stage/mem_access.sv
`timescale 1ns/1ns

module mem_access
    import rooth_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  mem_op_t                      op_i,

    // word ram
    output logic                         ram_en_o,
    output logic                         ram_we_o,
    output logic [$clog2(RAM_WORDS)-1:0] ram_addr_o,
    output logic [XLEN-1:0]              ram_wdata_o,
    input  logic [XLEN-1:0]              ram_rdata_i,

    // csr bank
    output logic [CSR_AW-1:0]            csr_idx_o,
    output logic                         csr_we_o,
    output logic [XLEN-1:0]              csr_wdata_o,
    input  logic [XLEN-1:0]              csr_rdata_i,

    output wb_t                          res_o,
    output logic                         res_valid_o,
    output logic                         stall_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic            ram_acc;
    logic            is_store;
    logic            phase_q;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] ld_data;

    assign is_store = (op_i.kind == ACC_STORE);
    assign ram_acc  = op_i.valid && op_i.in_ram &&
                      ((op_i.kind == ACC_LOAD) || is_store);

    // ------------------------------------------------------------------
    // phase 0 reads the old word, phase 1 writes or extracts
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= 1'b0;
        end else begin
            phase_q <= ram_acc && !phase_q;
        end
    end

    assign stall_o     = ram_acc && !phase_q;
    assign res_valid_o = op_i.valid && (!ram_acc || phase_q);

    assign ram_en_o   = ram_acc && (!phase_q || is_store);  // loads keep rdata in phase 1
    assign ram_we_o   = ram_acc && phase_q && is_store;
    assign ram_addr_o = op_i.alu_res[AW+1:2];

    // store merge into the old word
    always_comb begin
        case (op_i.funct3)
            F3_SB: begin
                case (op_i.lane)
                    2'd0:    ram_wdata_o = {ram_rdata_i[31:8], op_i.rs2[7:0]};
                    2'd1:    ram_wdata_o = {ram_rdata_i[31:16], op_i.rs2[7:0],
                                            ram_rdata_i[7:0]};
                    2'd2:    ram_wdata_o = {ram_rdata_i[31:24], op_i.rs2[7:0],
                                            ram_rdata_i[15:0]};
                    default: ram_wdata_o = {op_i.rs2[7:0], ram_rdata_i[23:0]};
                endcase
            end
            F3_SH: begin
                if (op_i.lane[1]) begin
                    ram_wdata_o = {op_i.rs2[15:0], ram_rdata_i[15:0]};
                end else begin
                    ram_wdata_o = {ram_rdata_i[31:16], op_i.rs2[15:0]};
                end
            end
            default: ram_wdata_o = op_i.rs2;    // sw
        endcase
    end

    // ------------------------------------------------------------------
    // load extraction
    // ------------------------------------------------------------------
    always_comb begin
        case (op_i.lane)
            2'd0:    ld_byte = ram_rdata_i[7:0];
            2'd1:    ld_byte = ram_rdata_i[15:8];
            2'd2:    ld_byte = ram_rdata_i[23:16];
            default: ld_byte = ram_rdata_i[31:24];
        endcase
        ld_half = op_i.lane[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

        case (op_i.funct3)
            F3_LB:   ld_data = {{24{ld_byte[7]}}, ld_byte};
            F3_LH:   ld_data = {{16{ld_half[15]}}, ld_half};
            F3_LBU:  ld_data = {24'h0, ld_byte};
            F3_LHU:  ld_data = {16'h0, ld_half};
            default: ld_data = ram_rdata_i;
        endcase
    end

    // csr new value, set/clear already done by execute
    assign csr_idx_o = op_i.csr_idx;
    assign csr_we_o  = op_i.valid && (op_i.kind == ACC_CSR);

    always_comb begin
        case (op_i.funct3)
            F3_CSRRW:  csr_wdata_o = op_i.rs1;
            F3_CSRRWI: csr_wdata_o = op_i.imm;
            default:   csr_wdata_o = op_i.alu_res;
        endcase
    end

    // ------------------------------------------------------------------
    // writeback record
    // ------------------------------------------------------------------
    always_comb begin
        res_o    = '0;
        res_o.rd = op_i.rd;
        case (op_i.kind)
            ACC_ALU: begin
                res_o.we   = 1'b1;
                res_o.data = op_i.alu_res;
            end
            ACC_CSR: begin
                res_o.we   = 1'b1;
                res_o.data = csr_rdata_i;   // old value
            end
            ACC_LOAD: begin
                res_o.we    = 1'b1;
                res_o.data  = op_i.in_ram ? ld_data : '0;
                res_o.fault = !op_i.in_ram;
            end
            ACC_STORE: res_o.fault = !op_i.in_ram;
            default: ;
        endcase
    end

endmodule

// File: rooth_mem.f
common/rooth_pkg.sv
source/mem_decode.sv
mem_stage/data_ram.sv
mem_stage/mem_access.sv
source/csr_bank.sv
source/wb_stage.sv
source/rooth_mem_top.sv
sim/tb_clk_gen.sv
sim/rooth_mem_sva.sv
sim/rooth_mem_tb.sv

// File: sim/rooth_mem_sva.sv
`timescale 1ns/1ns

module rooth_mem_sva #(
    parameter int AW = 8
) (
    input logic          clk,
    input logic          rst_n,
    input logic          stall_i,
    input logic          ram_we_i,
    input logic [AW-1:0] ram_addr_i,
    input logic          res_valid_i
);

    // a ram access stalls for its read phase only
    stall_single: assert property (
        @(posedge clk) disable iff (!rst_n) stall_i |=> !stall_i
    ) else $error("stall held high for two consecutive cycles");

    // write happens in the second phase, on the word just read
    we_no_stall: assert property (
        @(posedge clk) disable iff (!rst_n) ram_we_i |-> !stall_i && $stable(ram_addr_i)
    ) else $error("ram write while stalled or to a word that was not read");

    // a stalled access delivers its result in the following cycle
    res_no_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall_i |-> !res_valid_i ##1 res_valid_i
    ) else $error("result valid not held back by the stall or missing after it");

endmodule

bind mem_access rooth_mem_sva #(
    .AW (AW)
) i_rooth_mem_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (stall_o),
    .ram_we_i    (ram_we_o),
    .ram_addr_i  (ram_addr_o),
    .res_valid_i (res_valid_o)
);

// File: sim/rooth_mem_tb.sv
`timescale 1ns/1ns

module rooth_mem_tb
    import rooth_pkg::*;
();

    localparam int RAM_WORDS = 256;
    localparam int CSR_COUNT = 4;
    localparam int TIMEOUT   = 20;

    logic    clk;
    logic    rst_n;
    logic    valid_i;
    ex_mem_t ex_i;
    logic    stall_o;
    wb_t     wb_o;
    logic    wb_valid_o;

    int              errors;
    int              checks;
    logic [31:0]     lcg_state;
    logic [XLEN-1:0] ram_model [RAM_WORDS];
    logic [XLEN-1:0] csr_model [CSR_COUNT];

    tb_clk_gen #(.PERIOD(40), .RST_CYCLES(3)) i_tb_clk_gen (.clk(clk), .rst_n(rst_n));

    rooth_mem_top #(
        .RAM_WORDS (RAM_WORDS),
        .CSR_COUNT (CSR_COUNT)
    ) i_rooth_mem_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_i    (valid_i),
        .ex_i       (ex_i),
        .stall_o    (stall_o),
        .wb_o       (wb_o),
        .wb_valid_o (wb_valid_o)
    );

    // ------------------------------------------------------------------
    // random numbers and reference model
    // ------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] rand_word_addr();
        logic [31:0] r;
        r = lcg_next();
        return XLEN'({r[17:10], 2'b00});    // region 0, word aligned
    endfunction

    function automatic logic [REG_AW-1:0] rand_rd();
        logic [31:0] r;
        r = lcg_next();
        return r[20:16] | 5'd1;
    endfunction

    function automatic logic [XLEN-1:0] merge_store(logic [XLEN-1:0] old, logic [2:0] f3,
                                                    logic [1:0] lane, logic [XLEN-1:0] data);
        logic [XLEN-1:0] w;
        int              pos;
        w   = old;
        pos = int'(lane) * 8;
        if (f3 == F3_SB) begin
            w[pos +: 8] = data[7:0];
        end else if (f3 == F3_SH) begin
            w[pos +: 16] = data[15:0];
        end else begin
            w = data;
        end
        return w;
    endfunction

    function automatic logic [XLEN-1:0] extract_load(logic [XLEN-1:0] word, logic [2:0] f3,
                                                     logic [1:0] lane);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[int'(lane) * 8 +: 8];
        h = word[int'(lane[1]) * 16 +: 16];
        case (f3)
            F3_LB:   return {{24{b[7]}}, b};
            F3_LH:   return {{16{h[15]}}, h};
            F3_LBU:  return {24'h0, b};
            F3_LHU:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_wb(input string name, input wb_t got, input wb_t exp);
        string g;
        string e;
        checks++;
        if (got !== exp) begin
            errors++;
            g = $sformatf("we=%b rd=%0d data=%h fault=%b",
                          got.we, got.rd, got.data, got.fault);
            e = $sformatf("we=%b rd=%0d data=%h fault=%b",
                          exp.we, exp.rd, exp.data, exp.fault);
            $display("FAIL %0t %s got %s exp %s", $time, name, g, e);
        end
    endtask

    task automatic check_stall(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    // drive one instruction, then follow it to writeback
    task automatic run_instr(input string name, input ex_mem_t ex, input logic is_ram,
                             input wb_t exp);
        int   n;
        int   lat;
        logic done;
        lat = is_ram ? 3 : 2;   // accept edge to wb_valid_o edge
        @(posedge clk);
        #2;
        valid_i = 1'b1;
        ex_i    = ex;
        n = 0;
        @(negedge clk);
        while (stall_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stall_o) begin
            errors++;
            $display("%s was never accepted, stall_o stayed high", name);
        end
        @(posedge clk);
        #2;
        valid_i = 1'b0;
        n    = 0;
        done = 1'b0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            check_stall({name, " stall_o"}, stall_o, (n == 0) ? is_ram : 1'b0);
            done = wb_valid_o;
            n++;
        end
        if (!done) begin
            errors++;
            $display("%s timed out waiting for wb_valid_o", name);
        end else begin
            check_wb({name, " wb_o"}, wb_o, exp);
            checks++;
            if (n != lat) begin
                errors++;
                $display("FAIL %0t %s wb_valid_o latency got %0d exp %0d",
                         $time, name, n, lat);
            end
        end
    endtask

    task automatic write_mem(input logic [2:0] f3, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] data);
        ex_mem_t ex;
        wb_t     exp;
        logic    in_ram;
        int      idx;
        ex          = '0;
        ex.res_ctrl = RES_MEM;
        ex.funct3   = f3;
        ex.alu_res  = addr;
        ex.rs2      = data;
        in_ram      = (addr[31:28] == 4'h0);
        exp         = '0;
        exp.fault   = !in_ram;
        idx         = int'(addr[9:2]);
        if (in_ram) begin
            ram_model[idx] = merge_store(ram_model[idx], f3, addr[1:0], data);
        end
        run_instr("store", ex, in_ram, exp);
    endtask

    task automatic read_mem(input logic [2:0] f3, input logic [XLEN-1:0] addr,
                            input logic [REG_AW-1:0] rd);
        ex_mem_t ex;
        wb_t     exp;
        logic    in_ram;
        ex          = '0;
        ex.res_ctrl = RES_REG;
        ex.is_load  = 1'b1;
        ex.funct3   = f3;
        ex.rd       = rd;
        ex.alu_res  = addr;
        in_ram      = (addr[31:28] == 4'h0);
        exp.we      = (rd != '0);
        exp.rd      = rd;
        exp.data    = in_ram ? extract_load(ram_model[int'(addr[9:2])], f3, addr[1:0]) : '0;
        exp.fault   = !in_ram;
        run_instr("load", ex, in_ram, exp);
    endtask

    task automatic access_csr(input logic [2:0] f3, input int idx, input logic [XLEN-1:0] rs1,
                              input logic [XLEN-1:0] imm, input logic [XLEN-1:0] alu_res);
        ex_mem_t ex;
        wb_t     exp;
        ex          = '0;
        ex.res_ctrl = RES_CSR;
        ex.funct3   = f3;
        ex.rd       = rand_rd();
        ex.csr_idx  = CSR_AW'(idx);
        ex.rs1      = rs1;
        ex.imm      = imm;
        ex.alu_res  = alu_res;
        exp         = '0;
        exp.we      = 1'b1;
        exp.rd      = ex.rd;
        exp.data    = csr_model[idx];   // old value comes back
        if (f3 == F3_CSRRW) begin
            csr_model[idx] = rs1;
        end else if (f3 == F3_CSRRWI) begin
            csr_model[idx] = imm;
        end else begin
            csr_model[idx] = alu_res;
        end
        run_instr("csr", ex, 1'b0, exp);
    endtask

    task automatic pass_alu(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] value);
        ex_mem_t ex;
        wb_t     exp;
        ex          = '0;
        ex.res_ctrl = RES_REG;
        ex.rd       = rd;
        ex.alu_res  = value;
        exp.we      = (rd != '0);   // x0 never written
        exp.rd      = rd;
        exp.data    = value;
        exp.fault   = 1'b0;
        run_instr("alu", ex, 1'b0, exp);
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic alu_passthrough();
        repeat (4) pass_alu(rand_rd(), lcg_next());
        pass_alu('0, lcg_next());
    endtask

    task automatic word_roundtrip();
        logic [XLEN-1:0] a;
        repeat (4) begin
            a = rand_word_addr();
            write_mem(F3_SW, a, lcg_next());
            read_mem(F3_LW, a, rand_rd());
        end
    endtask

    task automatic subword_stores();
        logic [XLEN-1:0] a;
        a = rand_word_addr();
        for (int lane = 0; lane < 4; lane++) begin
            write_mem(F3_SW, a, lcg_next());
            write_mem(F3_SB, a + XLEN'(lane), lcg_next());
            read_mem(F3_LW, a, rand_rd());
            if (lane % 2 == 0) begin
                write_mem(F3_SW, a, lcg_next());
                write_mem(F3_SH, a + XLEN'(lane), lcg_next());
                read_mem(F3_LW, a, rand_rd());
            end
        end
    endtask

    task automatic subword_loads();
        logic [XLEN-1:0] a;
        repeat (2) begin
            a = rand_word_addr();
            write_mem(F3_SW, a, lcg_next());
            for (int lane = 0; lane < 4; lane++) begin
                read_mem(F3_LB, a + XLEN'(lane), rand_rd());
                read_mem(F3_LBU, a + XLEN'(lane), rand_rd());
                if (lane % 2 == 0) begin
                    read_mem(F3_LH, a + XLEN'(lane), rand_rd());
                    read_mem(F3_LHU, a + XLEN'(lane), rand_rd());
                end
            end
        end
    endtask

    task automatic csr_sequence();
        logic [XLEN-1:0] v;
        for (int idx = 1; idx < CSR_COUNT; idx += 2) begin
            access_csr(F3_CSRRW, idx, lcg_next(), '0, '0);
            v = lcg_next();
            access_csr(F3_CSRRWI, idx, '0, {27'h0, v[12:8]}, '0);
            v = lcg_next();
            access_csr(F3_CSRRS, idx, v, '0, csr_model[idx] | v);   // set done by execute
            access_csr(F3_CSRRW, idx, '0, '0, '0);
        end
    endtask

    task automatic out_of_region();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] far;
        logic [XLEN-1:0] d;
        a   = rand_word_addr();
        d   = lcg_next();
        far = {4'h2, a[27:0]};
        write_mem(F3_SW, a, d);
        write_mem(F3_SW, far, ~d);      // dropped
        read_mem(F3_LW, a, rand_rd());
        read_mem(F3_LW, far, rand_rd());
        read_mem(F3_LB, far + 1, rand_rd());
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int n;
        valid_i   = 1'b0;
        ex_i      = '0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h68ba;
        for (int i = 0; i < CSR_COUNT; i++) begin
            csr_model[i] = '0;
        end

        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end

        alu_passthrough();
        word_roundtrip();
        subword_stores();
        subword_loads();
        csr_sequence();
        out_of_region();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;    // release off the edge
    end

endmodule

// File: source/csr_bank.sv
`timescale 1ns/1ns

module csr_bank
    import rooth_pkg::*;
#(
    parameter int CSR_COUNT = 4
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic [CSR_AW-1:0] idx_i,
    input  logic              we_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   rdata_o
);

    localparam int SW = (CSR_COUNT > 1) ? $clog2(CSR_COUNT) : 1;

    logic [XLEN-1:0] csr_q [CSR_COUNT];
    logic            hit;
    logic [SW-1:0]   sel;

    assign hit = (idx_i < CSR_AW'(CSR_COUNT));
    assign sel = idx_i[SW-1:0];

    // combinational read, unmapped index reads zero
    assign rdata_o = hit ? csr_q[sel] : '0;

    // ------------------------------------------------------------------
    // clocked write
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < CSR_COUNT; i++) begin
                csr_q[i] <= '0;
            end
        end else if (we_i && hit) begin
            csr_q[sel] <= wdata_i;
        end
    end

endmodule

// File: source/mem_decode.sv
`timescale 1ns/1ns

module mem_decode
    import rooth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    valid_i,
    input  ex_mem_t ex_i,
    input  logic    stall_i,

    output mem_op_t op_o
);

    access_e kind;
    mem_op_t op_q;

    // classify from routing class and load flag
    always_comb begin
        case (ex_i.res_ctrl)
            RES_REG: begin
                if (ex_i.is_load) begin
                    kind = ACC_LOAD;
                end else begin
                    kind = ACC_ALU;
                end
            end
            RES_MEM:  kind = ACC_STORE;
            RES_CSR:  kind = ACC_CSR;
            default:  kind = ACC_NONE;
        endcase
    end

    // ------------------------------------------------------------------
    // op register, held while the access stage stalls
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= '0;
        end else if (!stall_i) begin
            op_q.valid   <= valid_i;    // bubble when nothing offered
            op_q.kind    <= kind;
            op_q.in_ram  <= (ex_i.alu_res[XLEN-1:XLEN-4] == 4'h0);
            op_q.lane    <= ex_i.alu_res[1:0];
            op_q.funct3  <= ex_i.funct3;
            op_q.rd      <= ex_i.rd;
            op_q.csr_idx <= ex_i.csr_idx;
            op_q.alu_res <= ex_i.alu_res;
            op_q.rs1     <= ex_i.rs1;
            op_q.rs2     <= ex_i.rs2;
            op_q.imm     <= ex_i.imm;
        end
    end

    assign op_o = op_q;

endmodule

// File: source/rooth_mem_top.sv
`timescale 1ns/1ns

module rooth_mem_top
    import rooth_pkg::*;
#(
    parameter int RAM_WORDS = 256,
    parameter int CSR_COUNT = 4
) (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    valid_i,
    input  ex_mem_t ex_i,
    output logic    stall_o,

    output wb_t     wb_o,
    output logic    wb_valid_o
);

    mem_op_t                      op;
    logic                         stall;
    logic                         ram_en;
    logic                         ram_we;
    logic [$clog2(RAM_WORDS)-1:0] ram_addr;
    logic [XLEN-1:0]              ram_wdata;
    logic [XLEN-1:0]              ram_rdata;
    logic [CSR_AW-1:0]            csr_idx;
    logic                         csr_we;
    logic [XLEN-1:0]              csr_wdata;
    logic [XLEN-1:0]              csr_rdata;
    wb_t                          res;
    logic                         res_valid;

    // ------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------
    mem_decode i_mem_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .ex_i    (ex_i),
        .stall_i (stall),
        .op_o    (op)
    );

    // ------------------------------------------------------------------
    // access, ram and csrs
    // ------------------------------------------------------------------
    mem_access #(
        .RAM_WORDS (RAM_WORDS)
    ) i_mem_access (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_i        (op),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .csr_idx_o   (csr_idx),
        .csr_we_o    (csr_we),
        .csr_wdata_o (csr_wdata),
        .csr_rdata_i (csr_rdata),
        .res_o       (res),
        .res_valid_o (res_valid),
        .stall_o     (stall)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_data_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    csr_bank #(
        .CSR_COUNT (CSR_COUNT)
    ) i_csr_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .idx_i   (csr_idx),
        .we_i    (csr_we),
        .wdata_i (csr_wdata),
        .rdata_o (csr_rdata)
    );

    // output side
    wb_stage i_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_i       (res),
        .res_valid_i (res_valid),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o)
    );

    assign stall_o = stall;

endmodule

// File: source/wb_stage.sv
`timescale 1ns/1ns

module wb_stage
    import rooth_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    input  wb_t  res_i,
    input  logic res_valid_i,

    output wb_t  wb_o,
    output logic wb_valid_o
);

    wb_t  wb_q;
    logic valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= res_valid_i;
            if (res_valid_i) begin
                wb_q    <= res_i;
                wb_q.we <= res_i.we && (res_i.rd != '0);   // x0 stays zero
            end
        end
    end

    assign wb_o       = wb_q;
    assign wb_valid_o = valid_q;

endmodule
